// ==== Bender.yml ====
package:
  name: raster_irq

sources:
  - files:
      - source/raster_pkg.sv
      - source/video_timing.sv
      - source/raster_line_cnt.sv
      - source/raster_pixel_cnt.sv
      - source/raster_unit.sv
      - source/raster_regs.sv
      - source/raster_top.sv
  - target: test
    files:
      - test/raster_assert.sv
      - test/raster_tb.sv

// ==== compile.f ====
source/raster_pkg.sv
source/video_timing.sv
source/raster_line_cnt.sv
source/raster_pixel_cnt.sv
source/raster_unit.sv
source/raster_regs.sv
source/raster_top.sv
test/raster_assert.sv
test/raster_tb.sv

// ==== source/raster_line_cnt.sv ====
/*
  Lockable scan-line down-counter.
  A CPU write loads start value and lock flag. The count reloads at frame
  start, or every cycle while locked, and otherwise steps down once per line.
  zero is registered; readback is sampled on cen4.
*/
`default_nettype none

module raster_line_cnt (
    input  wire               clk,
    input  wire               rst,
    input  wire               cen4,      // every second pixel
    input  wire               restart,   // frame start
    input  wire               step,      // line start
    input  wire               we,
    input  wire               lock,
    input  raster_pkg::cnt_t  din,
    output raster_pkg::cnt_t  dout,
    output logic              zero
);

    raster_pkg::cnt_t cnt_start;   // value written by the CPU
    raster_pkg::cnt_t cnt;         // live line count
    logic             locked;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_start <= raster_pkg::cnt_reset;
            cnt       <= raster_pkg::cnt_reset;
            dout      <= raster_pkg::cnt_reset;
            locked    <= 1'b0;
            zero      <= 1'b0;
        end else begin
            zero <= cnt == '0;          // one clk behind the count

            // readback shows the live count only when locked
            if (cen4)
                dout <= locked ? cnt : cnt_start;

            if (we) begin
                cnt_start <= din;
                locked    <= lock;
            end

            // write wins over everything else
            if (we)
                cnt <= din;
            else if (restart || locked)
                cnt <= cnt_start;       // locked counter holds its start value
            else if (step)
                cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/raster_pixel_cnt.sv ====
/*
  Horizontal down-counter for the raster unit.
  Runs at half pixel rate from the start value divided by two and reloads on
  every line start. Readback bit 0 is rebuilt from the cen4 phase, so the
  low bit of the readback toggles with the pixel phase.
*/
`default_nettype none

module raster_pixel_cnt (
    input  wire               clk,
    input  wire               rst,
    input  wire               pxl_cen,
    input  wire               cen4,      // every second pixel
    input  wire               restart,   // line start
    input  wire               we,
    input  raster_pkg::cnt_t  din,
    output raster_pkg::cnt_t  dout,
    output logic              zero
);

    localparam int hw = raster_pkg::cnt_w - 1;   // count runs in pixel pairs

    raster_pkg::cnt_t cnt_start;
    logic [hw-1:0]    cnt;
    logic [hw-1:0]    preout;        // sampled count for readback
    logic             pulse4;        // high for the pixel after cen4

    // low bit comes back from the start value and the pixel phase
    assign dout = {preout, cnt_start[0] ^ ~pulse4};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_start <= raster_pkg::cnt_reset;
            cnt       <= raster_pkg::cnt_reset[raster_pkg::cnt_w-1:1];
            preout    <= raster_pkg::cnt_reset[raster_pkg::cnt_w-1:1];
            pulse4    <= 1'b1;      // readback starts at all-ones
            zero      <= 1'b0;
        end else begin
            if (pxl_cen)
                pulse4 <= cen4;
            if (cen4)
                preout <= cnt;
            zero <= cnt == '0;

            if (we)
                cnt_start <= din;

            if (restart)
                cnt <= cnt_start[raster_pkg::cnt_w-1:1];   // start / 2
            else if (cen4)
                cnt <= cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/raster_pkg.sv ====
/*
  Shared types for the raster interrupt unit.
  Counter width, counter value type, reset value and the CPU register map.
  Modules refer to these by scoped names.
*/
`default_nettype none

package raster_pkg;

    localparam int cnt_w = 9;                      // line and pixel counter width

    typedef logic [cnt_w-1:0] cnt_t;               // start values, counts, readback

    localparam cnt_t cnt_reset = '1;               // counters wake up at all-ones

    // CPU register addresses
    typedef enum logic [1:0] {
        sel_line0 = 2'd0,   // line counter 0
        sel_line1 = 2'd1,   // line counter 1
        sel_pixel = 2'd2,   // pixel counter
        sel_irq   = 2'd3    // irq status, write acks
    } reg_sel_e;

endpackage

`default_nettype wire

// ==== source/raster_regs.sv ====
/*
  CPU register block of the raster unit.
  Turns write strobes into one-cycle counter loads, registers read data one
  clk after rd, and keeps the interrupt latch. Any write to the irq address
  acknowledges; a raster pulse in the same cycle keeps irq set.
*/
`default_nettype none

module raster_regs (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   wr,
    input  wire                   rd,
    input  raster_pkg::reg_sel_e  addr,
    input  wire  [15:0]           wdata,
    input  raster_pkg::cnt_t      cnt_dout,
    input  wire                   raster,
    output logic [2:0]            cnt_we,
    output logic                  lock,
    output raster_pkg::cnt_t      cnt_din,
    output raster_pkg::reg_sel_e  cnt_rsel,
    output logic [15:0]           rdata,
    output logic                  irq
);

    logic [2:0] we_dec;     // one-hot load enable from addr
    logic       ack;

    // readback mux in the unit follows the bus address directly
    assign cnt_rsel = addr;
    assign ack      = wr && addr == raster_pkg::sel_irq;

    always_comb begin
        we_dec = 3'b000;
        unique case (addr)
            raster_pkg::sel_line0: we_dec = 3'b001;
            raster_pkg::sel_line1: we_dec = 3'b010;
            raster_pkg::sel_pixel: we_dec = 3'b100;
            default:               we_dec = 3'b000;    // irq ack, no counter
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_we <= 3'b000;
            irq    <= 1'b0;
        end else begin
            cnt_we <= wr ? we_dec : 3'b000;    // single cycle pulse
            irq    <= raster || (irq && !ack); // new event beats the ack
        end
    end

    // load data rides along with cnt_we
    always_ff @(posedge clk) begin
        if (wr) begin
            cnt_din <= wdata[raster_pkg::cnt_w-1:0];
            lock    <= wdata[15];
        end
        if (rd) begin
            if (addr == raster_pkg::sel_irq)
                rdata <= {15'd0, irq};
            else
                rdata <= {{(16 - raster_pkg::cnt_w){1'b0}}, cnt_dout};
        end
    end

endmodule

`default_nettype wire

// ==== source/raster_top.sv ====
/*
  Top level of the raster interrupt unit.
  Connects the video timing generator, the raster counters and the CPU
  registers. Timing parameters are set here and passed to video_timing.
  The video strobes are brought out so line boundaries can be observed.
*/
`default_nettype none

module raster_top #(
    parameter int h_total = 512,
    parameter int v_total = 262,
    parameter int pxl_div = 2
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   wr,
    input  wire                   rd,
    input  raster_pkg::reg_sel_e  addr,
    input  wire  [15:0]           wdata,
    output logic [15:0]           rdata,
    output logic                  irq,
    output logic                  line_inc,
    output logic                  frame_start
);

    logic                  pxl_cen;
    logic [2:0]            cnt_we;
    logic                  lock;
    raster_pkg::cnt_t      cnt_din;
    raster_pkg::cnt_t      cnt_dout;
    raster_pkg::reg_sel_e  cnt_rsel;
    logic                  raster;

    video_timing #(
        .h_total (h_total),
        .v_total (v_total),
        .pxl_div (pxl_div)
    ) timing_i (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .line_inc    (line_inc),
        .frame_start (frame_start)
    );

    raster_unit unit_i (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .line_inc    (line_inc),
        .frame_start (frame_start),
        .cnt_we      (cnt_we),
        .lock        (lock),
        .cnt_din     (cnt_din),
        .cnt_rsel    (cnt_rsel),
        .cnt_dout    (cnt_dout),
        .raster      (raster)
    );

    raster_regs regs_i (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wdata    (wdata),
        .cnt_dout (cnt_dout),
        .raster   (raster),
        .cnt_we   (cnt_we),
        .lock     (lock),
        .cnt_din  (cnt_din),
        .cnt_rsel (cnt_rsel),
        .rdata    (rdata),
        .irq      (irq)
    );

endmodule

`default_nettype wire

// ==== source/raster_unit.sv ====
/*
  Raster event generator.
  Two lockable line counters and one pixel counter share the CPU load bus.
  A raster pulse is registered when the pixel counter and either line
  counter are at zero. cnt_dout is the readback of the selected counter.
*/
`default_nettype none

module raster_unit (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   pxl_cen,
    input  wire                   line_inc,
    input  wire                   frame_start,
    input  wire  [2:0]            cnt_we,      // one-hot: line0, line1, pixel
    input  wire                   lock,
    input  raster_pkg::cnt_t      cnt_din,
    input  raster_pkg::reg_sel_e  cnt_rsel,
    output raster_pkg::cnt_t      cnt_dout,
    output logic                  raster
);

    logic             restart;      // frame start on the pixel enable
    logic             step;         // line start on the pixel enable
    logic             cen4;         // every second pixel
    logic             phase;        // high on odd pixels of a line
    raster_pkg::cnt_t line0_dout;
    raster_pkg::cnt_t line1_dout;
    raster_pkg::cnt_t pixel_dout;
    logic             line0_zero;
    logic             line1_zero;
    logic             pixel_zero;

    assign restart = frame_start && pxl_cen;
    assign step    = line_inc && pxl_cen;
    assign cen4    = pxl_cen && phase;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase  <= 1'b0;
            raster <= 1'b0;
        end else begin
            if (pxl_cen)
                phase <= step || !phase;    // pixel 1 of each line gets cen4
            raster <= pixel_zero && (line0_zero || line1_zero);
        end
    end

    // readback select follows the CPU address
    always_comb begin
        case (cnt_rsel)
            raster_pkg::sel_line0: cnt_dout = line0_dout;
            raster_pkg::sel_line1: cnt_dout = line1_dout;
            raster_pkg::sel_pixel: cnt_dout = pixel_dout;
            default:               cnt_dout = raster_pkg::cnt_reset;   // irq status
        endcase
    end

    raster_line_cnt line0_i (
        .clk     (clk),
        .rst     (rst),
        .cen4    (cen4),
        .restart (restart),
        .step    (step),
        .we      (cnt_we[0]),
        .lock    (lock),
        .din     (cnt_din),
        .dout    (line0_dout),
        .zero    (line0_zero)
    );

    raster_line_cnt line1_i (
        .clk     (clk),
        .rst     (rst),
        .cen4    (cen4),
        .restart (restart),
        .step    (step),
        .we      (cnt_we[1]),
        .lock    (lock),
        .din     (cnt_din),
        .dout    (line1_dout),
        .zero    (line1_zero)
    );

    // pixel count restarts on every line
    raster_pixel_cnt pixel_i (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .cen4    (cen4),
        .restart (step),
        .we      (cnt_we[2]),
        .din     (cnt_din),
        .dout    (pixel_dout),
        .zero    (pixel_zero)
    );

endmodule

`default_nettype wire

// ==== source/video_timing.sv ====
/*
  Video timing generator for the raster unit.
  Divides clk into a pixel enable, then counts pixels per line and lines per frame.
  line_inc marks pixel 0 of every line, frame_start pixel 0 of line 0.
  Both strobes are only high together with pxl_cen.
*/
`default_nettype none

module video_timing #(
    parameter int h_total = 512,    // pixels per line
    parameter int v_total = 262,    // lines per frame
    parameter int pxl_div = 2       // clk cycles per pixel
) (
    input  wire  clk,
    input  wire  rst,
    output logic pxl_cen,
    output logic line_inc,
    output logic frame_start
);

    localparam int dw = (pxl_div > 1) ? $clog2(pxl_div) : 1;
    localparam int hw = (h_total > 1) ? $clog2(h_total) : 1;
    localparam int vw = (v_total > 1) ? $clog2(v_total) : 1;

    logic [dw-1:0] div_cnt;     // clk divider
    logic [hw-1:0] hcnt;        // pixel within line
    logic [vw-1:0] vcnt;        // line within frame
    logic          h_last;
    logic          v_last;

    assign pxl_cen = div_cnt == dw'(pxl_div - 1);
    assign h_last  = hcnt == hw'(h_total - 1);
    assign v_last  = vcnt == vw'(v_total - 1);

    // strobes sit on the first pixel, qualified by the pixel enable
    assign line_inc    = pxl_cen && hcnt == '0;
    assign frame_start = line_inc && vcnt == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            hcnt    <= '0;
            vcnt    <= '0;
        end else begin
            div_cnt <= pxl_cen ? '0 : div_cnt + 1'b1;
            if (pxl_cen) begin
                if (h_last) begin
                    hcnt <= '0;
                    vcnt <= v_last ? '0 : vcnt + 1'b1;   // wrap at frame end
                end else begin
                    hcnt <= hcnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/raster_assert.sv ====
/*
  Concurrent checks on raster_top internals, bound into the top level.
  Covers the irq rise rule, the one-hot counter load and the line strobe.
*/
`default_nettype none

module raster_assert (
    input wire       clk,
    input wire       rst,
    input wire       pxl_cen,
    input wire       line_inc,
    input wire [2:0] cnt_we,
    input wire       raster,
    input wire       irq
);

    timeunit 1ns;
    timeprecision 1ps;

    // irq latch only sets from a raster pulse one clk earlier
    irq_rise_needs_raster: assert property (
        @(posedge clk) disable iff (rst) $rose(irq) |-> $past(raster)
    ) else $error("irq rose without a raster pulse in the cycle before");

    // at most one counter loads per write
    cnt_we_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(cnt_we)
    ) else $error("more than one counter write enable is set");

    line_inc_with_pxl_cen: assert property (
        @(posedge clk) disable iff (rst) line_inc |-> pxl_cen
    ) else $error("line_inc is high without pxl_cen");

endmodule

bind raster_top raster_assert assert_i (
    .clk      (clk),
    .rst      (rst),
    .pxl_cen  (pxl_cen),
    .line_inc (line_inc),
    .cnt_we   (cnt_we),
    .raster   (raster),
    .irq      (irq)
);

`default_nettype wire

// ==== test/raster_tb.sv ====
/*
  Testbench for the raster interrupt unit.
  Drives CPU writes and reads on the falling edge, predicts the interrupt
  lines of a frame from the counter rules and checks readback and irq.
  Timing is shrunk to 16 lines of 32 pixels per frame.
*/
`default_nettype none

module raster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int h_total    = 32;
    localparam int v_total    = 16;
    localparam int pxl_div    = 2;
    localparam int n_tests    = 5;
    localparam int line_clks  = h_total * pxl_div;
    localparam int frame_clks = v_total * line_clks;
    localparam int bound_clks = n_tests * frame_clks * 3;   // watchdog limit

    logic                 clk;
    logic                 rst;
    logic                 wr;
    logic                 rd;
    raster_pkg::reg_sel_e addr;
    logic [15:0]          wdata;
    logic [15:0]          rdata;
    logic                 irq;
    logic                 line_inc;
    logic                 frame_start;

    int          errors;
    int          tests_run;
    int          tests_ok;
    int          test_err0;     // error count at test start
    logic [31:0] rand_state;
    int          line_idx;      // current line as seen by the monitor
    logic        frame_seen;    // a full frame can be measured
    logic        irq_q;
    int          irq_log[$];    // line of each irq rise

    raster_top #(
        .h_total (h_total),
        .v_total (v_total),
        .pxl_div (pxl_div)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr),
        .rd          (rd),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .irq         (irq),
        .line_inc    (line_inc),
        .frame_start (frame_start)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // line position and irq rises, sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            line_idx   = 0;
            frame_seen = 1'b0;
            irq_q      = 1'b0;
        end else begin
            if (frame_start) begin
                if (frame_seen && line_idx != v_total - 1) begin
                    $display("Mismatch at %0t: frame start after line %0d, expected line %0d",
                             $time, line_idx, v_total - 1);
                    errors++;
                end
                frame_seen = 1'b1;
                line_idx   = 0;
            end else if (line_inc) begin
                line_idx = line_idx + 1;
            end
            if (irq && !irq_q)
                irq_log.push_back(line_idx);
            irq_q = irq;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic roll(output logic [31:0] r);
        rand_state = xorshift32(rand_state);
        r = rand_state;
    endtask

    // one bit per line of a frame where an interrupt is due
    function automatic logic [31:0] irq_lines(input int s0, input logic lock0,
                                              input int s1, input logic lock1,
                                              input int p);
        logic [31:0] mask;
        logic        z0;
        logic        z1;
        mask = '0;
        for (int l = 0; l < v_total; l++) begin
            z0 = lock0 ? s0 == 0 : s0 == l;   // locked holds its start value
            z1 = lock1 ? s1 == 0 : s1 == l;   // unlocked hits zero after s steps
            mask[l] = (z0 || z1) && p < h_total;
        end
        return mask;
    endfunction

    task automatic write_reg(input raster_pkg::reg_sel_e a, input logic [15:0] d);
        @(negedge clk);
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr    = 1'b0;
    endtask

    task automatic read_reg(input raster_pkg::reg_sel_e a, output logic [15:0] d);
        @(negedge clk);
        rd   = 1'b1;
        addr = a;
        @(negedge clk);
        rd   = 1'b0;
        d    = rdata;    // registered one clk after rd
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!frame_start && n <= frame_clks);
        if (!frame_start) begin
            $display("No frame start seen within one frame at %0t", $time);
            errors++;
        end
    endtask

    task automatic wait_line_start();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!line_inc && n <= line_clks);
        if (!line_inc) begin
            $display("No line start seen within one line at %0t", $time);
            errors++;
        end
    endtask

    task automatic wait_irq_high();
        int n;
        n = 0;
        while (!irq && n <= line_clks) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            $display("irq did not rise within one line at %0t", $time);
            errors++;
        end
    endtask

    task automatic compare_cnt(input raster_pkg::cnt_t got, input raster_pkg::cnt_t exp,
                               input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_irq(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    // irq rises logged over one frame against the predicted lines
    task automatic check_irq_log(input logic [31:0] exp_mask, input string what);
        logic [31:0] seen;
        seen = '0;
        foreach (irq_log[i])
            seen[irq_log[i]] = 1'b1;
        if (irq_log.size() != $countones(exp_mask)) begin
            $display("Wrong number of interrupts in %s: %0d seen, %0d due",
                     what, irq_log.size(), $countones(exp_mask));
            errors++;
        end
        for (int l = 0; l < v_total; l++)
            compare_irq(seen[l], exp_mask[l], $sformatf("%s, irq in line %0d", what, l));
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    initial begin
        repeat (bound_clks) @(posedge clk);
        $display("Run stopped by the watchdog after %0d cycles", bound_clks);
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [15:0] d;
        logic [31:0] r;
        int          s0;
        int          s1;
        int          p;
        rst        = 1'b1;
        wr         = 1'b0;
        rd         = 1'b0;
        addr       = raster_pkg::sel_line0;
        wdata      = '0;
        errors     = 0;
        tests_run  = 0;
        tests_ok   = 0;
        test_err0  = 0;
        rand_state = 32'hfafc_4a75;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state, pixel first before its readback moves
        compare_irq(irq, 1'b0, "irq after reset");
        read_reg(raster_pkg::sel_pixel, d);
        compare_cnt(d[8:0], raster_pkg::cnt_reset, "pixel readback after reset");
        read_reg(raster_pkg::sel_line0, d);
        compare_cnt(d[8:0], raster_pkg::cnt_reset, "line0 readback after reset");
        read_reg(raster_pkg::sel_line1, d);
        compare_cnt(d[8:0], raster_pkg::cnt_reset, "line1 readback after reset");
        read_reg(raster_pkg::sel_irq, d);
        compare_irq(d[0], 1'b0, "irq status after reset");
        finish_test("reset state");

        roll(r);
        s0 = r[8:0];
        roll(r);
        s1 = r[8:0];
        roll(r);
        p = r[8:0];
        write_reg(raster_pkg::sel_line0, 16'(s0));
        write_reg(raster_pkg::sel_line1, 16'(s1));
        write_reg(raster_pkg::sel_pixel, 16'(p));
        repeat (5 * pxl_div) @(negedge clk);
        read_reg(raster_pkg::sel_line0, d);
        compare_cnt(d[8:0], raster_pkg::cnt_t'(s0), "line0 start value");
        read_reg(raster_pkg::sel_line1, d);
        compare_cnt(d[8:0], raster_pkg::cnt_t'(s1), "line1 start value");
        wait_line_start();
        repeat (4) @(negedge clk);   // sample lands after the reload, before the next step
        read_reg(raster_pkg::sel_pixel, d);
        compare_cnt({d[8:1], 1'b0}, raster_pkg::cnt_t'((p / 2) * 2), "pixel start / 2");
        finish_test("unlocked readback");

        roll(r);
        s0 = 1 + r % (v_total - 2);
        roll(r);
        p = 4 + r % (h_total - 4);
        write_reg(raster_pkg::sel_line1, 16'h01ff);     // parked out of reach
        write_reg(raster_pkg::sel_line0, 16'(s0));
        write_reg(raster_pkg::sel_pixel, 16'(p));
        wait_frame_start();
        write_reg(raster_pkg::sel_irq, 16'h0000);       // drop events of the load frame
        irq_log.delete();
        wait_frame_start();
        check_irq_log(irq_lines(s0, 1'b0, 511, 1'b0, p), "interrupt line");
        compare_irq(irq, 1'b1, "irq held to frame end");
        finish_test("interrupt line");

        write_reg(raster_pkg::sel_irq, 16'h0000);
        irq_log.delete();
        read_reg(raster_pkg::sel_irq, d);
        compare_irq(d[0], 1'b0, "irq status after ack");
        compare_irq(irq, 1'b0, "irq port after ack");
        repeat (s0) wait_line_start();
        compare_irq(irq, 1'b0, "irq port before predicted line");
        read_reg(raster_pkg::sel_irq, d);
        compare_irq(d[0], 1'b0, "irq status before predicted line");
        wait_frame_start();
        check_irq_log(irq_lines(s0, 1'b0, 511, 1'b0, p), "acknowledge");
        finish_test("acknowledge");

        roll(r);
        p = 4 + r % (h_total / 2 - 4);     // event comes well after the ack at line start
        write_reg(raster_pkg::sel_line0, 16'h01ff);
        write_reg(raster_pkg::sel_line1, 16'h8000);     // lock, start 0
        write_reg(raster_pkg::sel_pixel, 16'(p));
        wait_frame_start();
        write_reg(raster_pkg::sel_irq, 16'h0000);
        irq_log.delete();
        for (int l = 0; l < v_total; l++) begin
            wait_irq_high();
            wait_line_start();      // raster pulse is over by the next line
            write_reg(raster_pkg::sel_irq, 16'h0000);
        end
        check_irq_log(irq_lines(511, 1'b0, 0, 1'b1, p), "locked counter");
        finish_test("locked counter");

        $display("%0d of %0d tests ok, %0d errors", tests_ok, tests_run, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
